/* Makefile */
VERILATOR ?= verilator
TOP       := tb_pix_controller
RTL_TOP   := pix_controller
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^Test OK$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
logic/pix_pkg.sv
logic/pix_capture.sv
logic/pix_fifo.sv
logic/frame_ram_ctrl.sv
logic/pix_controller.sv
testbench/pix_sensor_model.sv
testbench/tb_pix_controller.sv

/* logic/frame_ram_ctrl.sv */
`timescale 1ns/1ps

module frame_ram_ctrl
    import pix_pkg::*;
#(
    parameter int image_size = 64
) (
    input  logic                  clk,
    input  logic                  reset,

    // Command port
    output logic                  cmd_ready,
    input  logic                  cmd_trigger,
    input  logic [block_bits-1:0] cmd_block,
    input  logic                  cmd_write,
    input  logic                  cmd_abort,

    // Write stream
    output logic                  write_ready,
    input  logic                  write_trigger,
    input  logic [word_width-1:0] write_data,

    // Read stream
    output logic                  read_ready,
    input  logic                  read_trigger,
    output logic [word_width-1:0] read_data
);

    localparam int cnt_w  = $clog2(image_size);
    localparam int addr_w = block_bits + cnt_w;

    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(image_size - 1);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_write = 2'd1;
    localparam logic [1:0] st_read  = 2'd2;

    logic [word_width-1:0] mem [0:(2**addr_w)-1];

    logic [1:0]            state;
    logic [block_bits-1:0] blk;
    logic [cnt_w-1:0]      cnt;
    logic [addr_w-1:0]     addr;
    logic                  load_read;

    // Block number selects the upper address bits
    assign addr = {blk, cnt};

    assign cmd_ready   = (state == st_idle);
    assign write_ready = (state == st_write);

    // Next read word is fetched whenever the read port is empty
    assign load_read = (state == st_read) && !read_ready;

    // ==================================================
    // Control
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            cnt        <= '0;
            read_ready <= 1'b0;
        end else if (cmd_abort) begin
            state      <= st_idle;
            read_ready <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (cmd_trigger) begin
                        state      <= cmd_write ? st_write : st_read;
                        cnt        <= '0;
                        read_ready <= 1'b0;
                    end
                end

                st_write: begin
                    if (write_trigger) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == cnt_last) begin
                            state <= st_idle;
                        end
                    end
                end

                st_read: begin
                    if (read_ready && read_trigger) begin
                        read_ready <= 1'b0;
                        if (cnt == cnt_last) begin
                            state <= st_idle;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end else if (load_read) begin
                        read_ready <= 1'b1;
                    end
                end

                default: state <= st_idle;
            endcase
        end
    end

    // ==================================================
    // Memory array
    // ==================================================
    always_ff @(posedge clk) begin
        if (cmd_ready && cmd_trigger) begin
            blk <= cmd_block;
        end
        if (write_ready && write_trigger) begin
            mem[addr] <= write_data;
        end
        // Registered read port
        if (load_read) begin
            read_data <= mem[addr];
        end
    end

endmodule

/* logic/pix_capture.sv */
`timescale 1ns/1ps

module pix_capture
    import pix_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  abort,
    input  logic                  pix_valid,
    input  logic [pix_width-1:0]  pix_d,
    input  logic                  pix_fv,
    input  logic                  pix_lv,
    input  logic                  w_ready,
    output logic                  w_trigger,
    output logic [word_width-1:0] w_data
);

    localparam logic [1:0] st_idle     = 2'd0;
    localparam logic [1:0] st_wait_inv = 2'd1;
    localparam logic [1:0] st_wait_sof = 2'd2;
    localparam logic [1:0] st_frame    = 2'd3;

    logic [1:0]           state;
    logic                 valid_q;
    logic                 fv_q;
    logic                 lv_q;
    logic [pix_width-1:0] d_q;
    logic                 in_frame;

    // ==================================================
    // Input registers
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            fv_q    <= 1'b0;
            lv_q    <= 1'b0;
        end else begin
            valid_q <= pix_valid;
            fv_q    <= pix_fv;
            lv_q    <= pix_lv;
        end
    end

    always_ff @(posedge clk) begin
        d_q <= pix_d;
    end

    // ==================================================
    // Frame sync
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else if (abort) begin
            state <= st_idle;
        end else if (start) begin
            // A frame already running is skipped
            state <= st_wait_inv;
        end else begin
            case (state)
                st_wait_inv: if (!fv_q) state <= st_wait_sof;
                st_wait_sof: if (fv_q) state <= st_frame;
                st_frame:    if (!fv_q) state <= st_idle;
                default:     state <= st_idle;
            endcase
        end
    end

    // The first cycle of frame valid already counts as in-frame
    assign in_frame = (state == st_frame) || ((state == st_wait_sof) && fv_q);

    // Pixel is dropped when the FIFO has no room
    assign w_trigger = in_frame && fv_q && lv_q && valid_q && w_ready;
    assign w_data    = {{(word_width - pix_width){1'b0}}, d_q};

endmodule

/* logic/pix_controller.sv */
`timescale 1ns/1ps

module pix_controller
    import pix_pkg::*;
#(
    parameter int image_size = 64,
    parameter int fifo_depth = 8
) (
    input  logic                  clk,
    input  logic                  reset,

    // Command port
    output logic                  cmd_ready,
    input  logic                  cmd_trigger,
    input  logic                  cmd,
    input  logic [block_bits-1:0] cmd_block,
    input  logic                  cmd_abort,

    // Readout port
    output logic                  readout_ready,
    input  logic                  readout_trigger,
    output logic [word_width-1:0] readout_data,

    // Pixel port
    input  logic                  pix_valid,
    input  logic [pix_width-1:0]  pix_d,
    input  logic                  pix_fv,
    input  logic                  pix_lv
);

    localparam logic [2:0] st_idle       = 3'd0;
    localparam logic [2:0] st_cap_issue  = 3'd1;
    localparam logic [2:0] st_cap_copy   = 3'd2;
    localparam logic [2:0] st_rd_issue   = 3'd3;
    localparam logic [2:0] st_rd_wait    = 3'd4;
    localparam logic [2:0] st_abort      = 3'd5;
    localparam logic [2:0] st_abort_wait = 3'd6;

    logic [2:0]            state;

    logic                  cap_start;
    logic                  cap_abort;

    logic                  fifo_flush;
    logic                  fifo_w_ready;
    logic                  fifo_w_trigger;
    logic [word_width-1:0] fifo_w_data;
    logic                  fifo_r_ready;
    logic                  fifo_r_trigger;
    logic [word_width-1:0] fifo_r_data;

    logic                  mem_cmd_ready;
    logic                  mem_cmd_trigger;
    logic [block_bits-1:0] mem_cmd_block;
    logic                  mem_cmd_write;
    logic                  mem_cmd_abort;
    logic                  mem_write_ready;
    logic                  mem_write_trigger;
    logic [word_width-1:0] mem_write_data;

    // ==================================================
    // Datapath blocks
    // ==================================================
    pix_capture i_pix_capture (
        .clk       (clk),
        .reset     (reset),
        .start     (cap_start),
        .abort     (cap_abort),
        .pix_valid (pix_valid),
        .pix_d     (pix_d),
        .pix_fv    (pix_fv),
        .pix_lv    (pix_lv),
        .w_ready   (fifo_w_ready),
        .w_trigger (fifo_w_trigger),
        .w_data    (fifo_w_data)
    );

    pix_fifo #(
        .depth (fifo_depth)
    ) i_pix_fifo (
        .clk       (clk),
        .reset     (reset),
        .flush     (fifo_flush),
        .w_ready   (fifo_w_ready),
        .w_trigger (fifo_w_trigger),
        .w_data    (fifo_w_data),
        .r_ready   (fifo_r_ready),
        .r_trigger (fifo_r_trigger),
        .r_data    (fifo_r_data)
    );

    // Read stream goes straight out on the readout port
    frame_ram_ctrl #(
        .image_size (image_size)
    ) i_frame_ram_ctrl (
        .clk           (clk),
        .reset         (reset),
        .cmd_ready     (mem_cmd_ready),
        .cmd_trigger   (mem_cmd_trigger),
        .cmd_block     (mem_cmd_block),
        .cmd_write     (mem_cmd_write),
        .cmd_abort     (mem_cmd_abort),
        .write_ready   (mem_write_ready),
        .write_trigger (mem_write_trigger),
        .write_data    (mem_write_data),
        .read_ready    (readout_ready),
        .read_trigger  (readout_trigger),
        .read_data     (readout_data)
    );

    // Pop a word only when the write register is free or being emptied
    // and no flush is pending
    assign fifo_r_trigger = (state == st_cap_copy) && !fifo_flush &&
                            (!mem_write_trigger || mem_write_ready);

    // ==================================================
    // Command FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state             <= st_idle;
            cmd_ready         <= 1'b0;
            mem_cmd_trigger   <= 1'b0;
            mem_cmd_abort     <= 1'b0;
            mem_write_trigger <= 1'b0;
            cap_start         <= 1'b0;
            cap_abort         <= 1'b0;
            fifo_flush        <= 1'b0;
        end else begin
            // Pulses default low
            cmd_ready     <= 1'b0;
            mem_cmd_abort <= 1'b0;
            cap_start     <= 1'b0;
            cap_abort     <= 1'b0;
            fifo_flush    <= 1'b0;

            case (state)
                st_idle: begin
                    if (cmd_ready && cmd_trigger) begin
                        mem_cmd_block <= cmd_block;
                        mem_cmd_write <= (cmd == cmd_capture);
                        state <= (cmd == cmd_readout) ? st_rd_issue : st_cap_issue;
                    end else begin
                        cmd_ready <= 1'b1;
                    end
                end

                // Hold the memory command until it is taken
                st_cap_issue: begin
                    mem_cmd_trigger <= 1'b1;
                    if (mem_cmd_ready && mem_cmd_trigger) begin
                        mem_cmd_trigger <= 1'b0;
                        cap_start       <= 1'b1;
                        fifo_flush      <= 1'b1;
                        state           <= st_cap_copy;
                    end
                end

                st_cap_copy: begin
                    if (mem_write_ready && mem_write_trigger) begin
                        mem_write_trigger <= 1'b0;
                    end
                    if (fifo_r_ready && fifo_r_trigger) begin
                        mem_write_data    <= fifo_r_data;
                        mem_write_trigger <= 1'b1;
                    end
                    // Leftover pixels are dropped once the block is full
                    if (mem_cmd_ready) begin
                        mem_write_trigger <= 1'b0;
                        fifo_flush        <= 1'b1;
                        state             <= st_idle;
                    end
                end

                st_rd_issue: begin
                    mem_cmd_trigger <= 1'b1;
                    if (mem_cmd_ready && mem_cmd_trigger) begin
                        mem_cmd_trigger <= 1'b0;
                        state           <= st_rd_wait;
                    end
                end

                st_rd_wait: begin
                    if (mem_cmd_ready) state <= st_idle;
                end

                // Memory controller takes the abort here
                st_abort: begin
                    state <= st_abort_wait;
                end

                st_abort_wait: begin
                    if (mem_cmd_ready) begin
                        cmd_ready <= 1'b1;
                        state     <= st_idle;
                    end
                end

                default: state <= st_idle;
            endcase

            // Abort wins over whatever is in progress
            if (cmd_abort) begin
                mem_cmd_abort     <= 1'b1;
                cap_abort         <= 1'b1;
                fifo_flush        <= 1'b1;
                cmd_ready         <= 1'b0;
                mem_cmd_trigger   <= 1'b0;
                mem_write_trigger <= 1'b0;
                state             <= st_abort;
            end
        end
    end

endmodule

/* logic/pix_fifo.sv */
`timescale 1ns/1ps

module pix_fifo
    import pix_pkg::*;
#(
    parameter int depth = 8
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    output logic                  w_ready,
    input  logic                  w_trigger,
    input  logic [word_width-1:0] w_data,
    output logic                  r_ready,
    input  logic                  r_trigger,
    output logic [word_width-1:0] r_data
);

    localparam int addr_w = $clog2(depth);

    logic [word_width-1:0] mem [0:depth-1];

    // Top bit of each pointer is the wrap bit
    logic [addr_w:0] wr_ptr;
    logic [addr_w:0] rd_ptr;
    logic            full;
    logic            empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                   (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

    assign w_ready = !full;
    assign r_ready = !empty;
    assign r_data  = mem[rd_ptr[addr_w-1:0]];

    // ==================================================
    // Pointers
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (w_ready && w_trigger) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (r_ready && r_trigger) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (w_ready && w_trigger) begin
            mem[wr_ptr[addr_w-1:0]] <= w_data;
        end
    end

endmodule

/* logic/pix_pkg.sv */
package pix_pkg;

    // ==================================================
    // Data widths
    // ==================================================

    // Bits per sensor pixel
    localparam int pix_width = 12;

    // Bits per stored word with the pixel in the low bits
    localparam int word_width = 16;

    // ==================================================
    // Command port
    // ==================================================

    // Encodings of the cmd input
    localparam logic cmd_capture = 1'b0;
    localparam logic cmd_readout = 1'b1;

    // Width of the frame memory block select
    localparam int block_bits = 3;

endpackage

/* testbench/pix_sensor_model.sv */
`timescale 1ns/1ps

module pix_sensor_model
    import pix_pkg::*;
#(
    parameter int inv_len  = 20,
    parameter int lines    = 4,
    parameter int line_len = 16,
    parameter int lv_len   = 12
) (
    input  logic                 clk,
    input  logic                 reset,
    output logic                 pix_valid,
    output logic [pix_width-1:0] pix_d,
    output logic                 pix_fv,
    output logic                 pix_lv,
    output int                   frame_id
);

    localparam int frame_len = inv_len + lines * line_len;

    int   pos;
    int   frame_num;
    int   idx;
    int   k;
    logic fv_n;
    logic lv_n;
    logic valid_n;

    // Frame period is the invalid gap followed by the lines
    always_comb begin
        fv_n    = (pos >= inv_len);
        k       = pos - inv_len;
        lv_n    = fv_n && ((k % line_len) < lv_len);
        valid_n = ((pos % 2) == 0);
    end

    // ==================================================
    // Output registers
    // ==================================================
    always @(posedge clk) begin
        if (reset) begin
            pos       <= 0;
            frame_num <= 0;
            idx       <= 0;
            frame_id  <= 0;
            pix_fv    <= 1'b0;
            pix_lv    <= 1'b0;
            pix_valid <= 1'b0;
            pix_d     <= '0;
        end else begin
            pix_fv    <= fv_n;
            pix_lv    <= lv_n;
            pix_valid <= valid_n;
            frame_id  <= frame_num;
            if (fv_n && lv_n && valid_n) begin
                pix_d <= pix_width'((frame_num * 37 + idx) % 4096);
                idx   <= idx + 1;
            end else begin
                // Filler on unqualified cycles
                pix_d <= pix_width'(pos * 5 + 3);
            end
            if (pos == frame_len - 1) begin
                pos       <= 0;
                frame_num <= frame_num + 1;
                idx       <= 0;
            end else begin
                pos <= pos + 1;
            end
        end
    end

endmodule

/* testbench/tb_pix_controller.sv */
`timescale 1ns/1ps

module tb_pix_controller
    import pix_pkg::*;
();

    localparam int image_size     = 16;
    localparam int frame_len      = 20 + 4 * 16;
    localparam int timeout_cycles = 40 * frame_len;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  cmd_ready;
    logic                  cmd_trigger;
    logic                  cmd;
    logic [block_bits-1:0] cmd_block;
    logic                  cmd_abort;
    logic                  readout_ready;
    logic                  readout_trigger = 1'b0;
    logic [word_width-1:0] readout_data;
    logic                  pix_valid;
    logic [pix_width-1:0]  pix_d;
    logic                  pix_fv;
    logic                  pix_lv;
    int                    frame_id;

    logic [word_width-1:0] expected [0:8*image_size-1];
    logic [word_width-1:0] exp_word;
    int                    errors = 0;
    int                    cycles = 0;
    int                    reset_cycles = 0;
    int                    abort_cnt = 0;
    int                    seed;
    int                    rnd;
    int                    rd_blk = 0;
    int                    rd_idx = 0;
    logic                  rd_active = 1'b0;
    logic                  rd_random = 1'b0;

    pix_controller #(
        .image_size (image_size),
        .fifo_depth (8)
    ) i_pix_controller (
        .clk             (clk),
        .reset           (reset),
        .cmd_ready       (cmd_ready),
        .cmd_trigger     (cmd_trigger),
        .cmd             (cmd),
        .cmd_block       (cmd_block),
        .cmd_abort       (cmd_abort),
        .readout_ready   (readout_ready),
        .readout_trigger (readout_trigger),
        .readout_data    (readout_data),
        .pix_valid       (pix_valid),
        .pix_d           (pix_d),
        .pix_fv          (pix_fv),
        .pix_lv          (pix_lv)
    );

    pix_sensor_model i_sensor (
        .clk       (clk),
        .reset     (reset),
        .pix_valid (pix_valid),
        .pix_d     (pix_d),
        .pix_fv    (pix_fv),
        .pix_lv    (pix_lv),
        .frame_id  (frame_id)
    );

    always #2 clk = ~clk;

    // ==================================================
    // Monitors and host side of the readout port
    // ==================================================
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_cycles);
            $display("Errors: %0d", errors);
            $display("Test FAILED");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (reset) reset_cycles <= reset_cycles + 1;
        if (cmd_abort) abort_cnt <= 1;
        else if (cmd_ready) abort_cnt <= 0;
        else if (abort_cnt != 0) abort_cnt <= abort_cnt + 1;
    end

    // Word counter of the running readout
    always @(posedge clk) begin
        if (!rd_active) rd_idx <= 0;
        else if (readout_ready && readout_trigger) rd_idx <= rd_idx + 1;
        if (rd_active && rd_random) begin
            rnd = $random(seed);
            readout_trigger <= (rnd[1:0] != 2'b00);
        end else begin
            readout_trigger <= rd_active;
        end
    end

    always_comb exp_word = expected[(rd_blk * image_size + rd_idx) % (8 * image_size)];

    // ==================================================
    // Assertions
    // ==================================================
    assert property (@(posedge clk) (reset && reset_cycles != 0) |-> (!cmd_ready && !readout_ready))
        else begin
            errors = errors + 1;
            $display("A ready output was high during reset");
        end

    assert property (@(posedge clk) $fell(reset) |=> cmd_ready)
        else begin
            errors = errors + 1;
            $display("cmd_ready did not rise on the first cycle after reset");
        end

    assert property (@(posedge clk) disable iff (reset) (cmd_ready && cmd_trigger) |=> !cmd_ready)
        else begin
            errors = errors + 1;
            $display("cmd_ready stayed high after a command was accepted");
        end

    assert property (@(posedge clk) disable iff (reset)
            (readout_ready && readout_trigger) |-> (readout_data == exp_word))
        else begin
            errors = errors + 1;
            $display("Fail readout_data block %0d word %0d: got %h expected %h",
                     rd_blk, $sampled(rd_idx), $sampled(readout_data), $sampled(exp_word));
        end

    assert property (@(posedge clk) disable iff (reset)
            (readout_ready && readout_trigger) |-> (rd_active && rd_idx < image_size))
        else begin
            errors = errors + 1;
            $display("A readout word arrived outside a readout or past the block end");
        end

    // Stalled word must stay on the port
    assert property (@(posedge clk) disable iff (reset)
            (readout_ready && !readout_trigger) |=>
            (readout_ready && readout_data == $past(readout_data)))
        else begin
            errors = errors + 1;
            $display("The readout word was not held while the host stalled");
        end

    assert property (@(posedge clk) disable iff (reset) abort_cnt <= 4)
        else begin
            errors = errors + 1;
            $display("cmd_ready did not return within 4 cycles of an abort");
        end

    // ==================================================
    // Host tasks
    // ==================================================
    task automatic send_cmd(input logic c, input int blk);
        while (!cmd_ready) @(posedge clk);
        cmd_trigger <= 1'b1;
        cmd         <= c;
        cmd_block   <= block_bits'(blk);
        @(posedge clk);
        cmd_trigger <= 1'b0;
    endtask

    task automatic wait_done();
        do @(posedge clk); while (!cmd_ready);
    endtask

    // Zero abort_after means the capture runs to completion
    task automatic capture_block(input int blk, input logic mid_frame, input int abort_after);
        int f;
        @(posedge clk);
        while (!cmd_ready) @(posedge clk);
        while (!pix_fv) @(posedge clk);
        if (mid_frame) repeat (8) @(posedge clk);
        else while (pix_fv) @(posedge clk);
        // A frame already running is skipped
        f = pix_fv ? frame_id + 1 : frame_id;
        send_cmd(cmd_capture, blk);
        if (abort_after > 0) begin
            repeat (abort_after) @(posedge clk);
            cmd_abort <= 1'b1;
            @(posedge clk);
            cmd_abort <= 1'b0;
        end else begin
            for (int i = 0; i < image_size; i++) begin
                expected[blk * image_size + i] = word_width'((f * 37 + i) % 4096);
            end
        end
        wait_done();
    endtask

    task automatic read_block(input int blk, input logic random_stall);
        @(posedge clk);
        rd_blk    <= blk;
        rd_random <= random_stall;
        rd_active <= 1'b1;
        send_cmd(cmd_readout, blk);
        wait_done();
        rd_active <= 1'b0;
        assert (rd_idx == image_size)
            else begin
                errors = errors + 1;
                $display("Fail readout word count: got %h expected %h", rd_idx, image_size);
            end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        seed = 32'hd3379f92;
        for (int i = 0; i < 8 * image_size; i++) expected[i] = '0;
        reset       <= 1'b1;
        cmd_trigger <= 1'b0;
        cmd         <= 1'b0;
        cmd_block   <= '0;
        cmd_abort   <= 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        capture_block(0, 1'b0, 0);
        read_block(0, 1'b0);

        capture_block(2, 1'b0, 0);
        capture_block(5, 1'b0, 0);
        read_block(2, 1'b1);
        read_block(5, 1'b1);

        capture_block(1, 1'b1, 0);
        read_block(1, 1'b1);

        // Block 5 has to survive an aborted capture
        capture_block(2, 1'b0, 30);
        read_block(5, 1'b1);

        repeat (4) @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
